// File: source/riscv_v_ctrl_pkg.sv
// Control encodings for the vector logic slice
// Op codes are internal to this slice and do not follow the funct6 layout
// SEW codes follow vtype.vsew, codes 5 to 7 are reserved and never decoded
package riscv_v_ctrl_pkg;

    typedef enum logic [3:0] {
        OP_AND    = 4'd0,
        OP_OR     = 4'd1,
        OP_XOR    = 4'd2,
        OP_REDAND = 4'd3,
        OP_REDOR  = 4'd4,
        OP_REDXOR = 4'd5,
        OP_SLL    = 4'd6,
        OP_SRL    = 4'd7,
        OP_SRA    = 4'd8
    } riscv_v_op_e;

    typedef enum logic [2:0] {
        SEW_8   = 3'd0,
        SEW_16  = 3'd1,
        SEW_32  = 3'd2,
        SEW_64  = 3'd3,
        SEW_128 = 3'd4
    } riscv_v_sew_e;

    // One-hot, bit 0 is 8 bits and bit 4 is 128 bits
    typedef logic [4:0] osize_vector_t;

    localparam osize_vector_t OSIZE_8 = 5'b00001;

    typedef struct packed {
        logic is_reduct;
        logic is_and;
        logic is_or;
        logic is_xor;
        logic is_shift;
        logic is_left;
        logic is_arith;
    } riscv_v_logic_ctrl_t;

endpackage

// File: source/riscv_v_pkg.sv
// Data types for one 128-bit vector register in a single lane
// No LMUL grouping, a register group is always one register
// Element views cover SEW 8 to 128, element 0 sits in the low bits
package riscv_v_pkg;

    localparam int VLEN  = 128;
    localparam int VLENB = VLEN / 8;

    // One register seen at every element size
    typedef union packed {
        logic [VLENB-1:0][7:0]        b;
        logic [VLENB/2-1:0][15:0]     h;
        logic [VLENB/4-1:0][31:0]     w;
        logic [VLENB/8-1:0][63:0]     d;
        logic [VLEN-1:0]              q;
    } riscv_v_lane_u;

    // Operand, valid doubles as the issue strobe
    typedef struct packed {
        logic          valid;
        riscv_v_lane_u data;
    } riscv_v_alu_data_t;

    // Writeback to the register file side
    typedef struct packed {
        logic          valid;
        riscv_v_lane_u data;
    } riscv_v_wb_data_t;

endpackage

// File: source/riscv_v_alu_cfg.sv
// Holds the current element size as a one-hot vector
// Reserved vsew codes are ignored and raise cfg_err until reset
// A new size applies to operations issued on the following cycle
`timescale 1ns/1ns

module riscv_v_alu_cfg (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_we,
    input  riscv_v_ctrl_pkg::riscv_v_sew_e  cfg_sew,
    output riscv_v_ctrl_pkg::osize_vector_t osize_vector,
    output logic                           cfg_err
);
    import riscv_v_ctrl_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            osize_vector <= OSIZE_8;
            cfg_err      <= 1'b0;
        end else if (cfg_we) begin
            case (cfg_sew)
                SEW_8:   osize_vector <= 5'b00001;
                SEW_16:  osize_vector <= 5'b00010;
                SEW_32:  osize_vector <= 5'b00100;
                SEW_64:  osize_vector <= 5'b01000;
                SEW_128: osize_vector <= 5'b10000;
                // Reserved code, keep the old size
                default: cfg_err <= 1'b1;
            endcase
        end
    end

    // Datapath masks assume exactly one size is active
    a_osize_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(osize_vector)
    );

endmodule

// File: source/riscv_v_bw_unit.sv
// AND, OR and XOR, element-wise or as a reduction into element 0
// Reductions fold all srcb elements, then combine with srca element 0
// Output is zero when none of the three op flags is set
`timescale 1ns/1ns

module riscv_v_bw_unit (
    input  riscv_v_ctrl_pkg::riscv_v_logic_ctrl_t ctrl,
    input  riscv_v_ctrl_pkg::osize_vector_t       osize_vector,
    input  logic [4:1]                           is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_alu_data_t        srca,
    input  riscv_v_pkg::riscv_v_alu_data_t        srcb,
    output riscv_v_pkg::riscv_v_lane_u            result
);
    import riscv_v_ctrl_pkg::*;
    import riscv_v_pkg::*;

    riscv_v_lane_u   fold64;
    riscv_v_lane_u   fold32;
    riscv_v_lane_u   fold16;
    riscv_v_lane_u   fold8;
    logic [VLEN-1:0] elem0_mask;
    logic [VLEN-1:0] red;

    function automatic logic [VLEN-1:0] apply_op(
        input riscv_v_logic_ctrl_t c,
        input logic [VLEN-1:0]     x,
        input logic [VLEN-1:0]     y
    );
        apply_op = ({VLEN{c.is_and}} & (x & y)) |
                   ({VLEN{c.is_or}}  & (x | y)) |
                   ({VLEN{c.is_xor}} & (x ^ y));
    endfunction

    // Halving tree, a stage passes through once the element is that wide
    assign fold64 = is_greater_osize_vector[4] ? srcb.data :
                    apply_op(ctrl, {64'b0, srcb.data.d[1]}, {64'b0, srcb.data.d[0]});
    assign fold32 = is_greater_osize_vector[3] ? fold64 :
                    apply_op(ctrl, {96'b0, fold64.w[1]}, {96'b0, fold64.w[0]});
    assign fold16 = is_greater_osize_vector[2] ? fold32 :
                    apply_op(ctrl, {112'b0, fold32.h[1]}, {112'b0, fold32.h[0]});
    assign fold8  = is_greater_osize_vector[1] ? fold16 :
                    apply_op(ctrl, {120'b0, fold16.b[1]}, {120'b0, fold16.b[0]});

    // Bits of element 0 at the current size
    assign elem0_mask = {{64{osize_vector[4]}},
                         {32{|osize_vector[4:3]}},
                         {16{|osize_vector[4:2]}},
                         {8{|osize_vector[4:1]}},
                         8'hff};

    assign red = apply_op(ctrl, srca.data.q & elem0_mask, fold8.q) & elem0_mask;

    // Element-wise ops do not depend on the size
    assign result = ctrl.is_reduct ? red : apply_op(ctrl, srca.data.q, srcb.data.q);

endmodule

// File: source/riscv_v_shifter.sv
// Per-element SLL, SRL and SRA over one register
// Shift amount is the low log2(SEW) bits of the matching srcb element
// Bits never cross an element boundary, SRA fills with the element sign
`timescale 1ns/1ns

module riscv_v_shifter (
    input  riscv_v_ctrl_pkg::riscv_v_logic_ctrl_t ctrl,
    input  riscv_v_ctrl_pkg::osize_vector_t       osize_vector,
    input  logic [3:0]                           is_less_osize_vector,
    input  logic [4:1]                           is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_alu_data_t        srca,
    input  riscv_v_pkg::riscv_v_alu_data_t        srcb,
    output riscv_v_pkg::riscv_v_lane_u            result
);
    import riscv_v_ctrl_pkg::*;
    import riscv_v_pkg::*;

    logic [6:0]                amt_mask;
    logic [6:0]                off_mask;
    logic [VLENB-1:0][6:0]     amt;
    logic [VLENB-1:0]          sign;
    logic [VLENB-1:0]          fill;
    logic [7:0][VLEN-1:0]      stg;

    // Valid amount bits and bit offset inside an element
    assign amt_mask = {~is_less_osize_vector, 3'b111};
    assign off_mask = {is_greater_osize_vector, 3'b111};

    // Every amount fits in the element's lowest byte
    always_comb begin
        for (int j = 0; j < VLENB; j++) begin
            amt[j] = srcb.data.b[4'(j) & ~is_greater_osize_vector][6:0] & amt_mask;
        end
    end

    // Sign of the element holding each byte
    for (genvar j = 0; j < VLENB; j++) begin : g_sign
        assign sign[j] = (osize_vector[0] & srca.data.b[j][7])
                       | (osize_vector[1] & srca.data.h[j/2][15])
                       | (osize_vector[2] & srca.data.w[j/4][31])
                       | (osize_vector[3] & srca.data.d[j/8][63])
                       | (osize_vector[4] & srca.data.q[VLEN-1]);
        assign fill[j] = ctrl.is_arith & sign[j];
    end

    // Log shifter, stage s moves by 2**s inside each byte's element
    always_comb begin : stage_net
        logic [6:0] off;
        int         k;
        stg[0] = srca.data.q;
        for (int s = 0; s < 7; s++) begin
            k = 1 << s;
            for (int i = 0; i < VLEN; i++) begin
                off = 7'(i) & off_mask;
                if (!amt[i/8][s]) begin
                    stg[s+1][i] = stg[s][i];
                end else if (ctrl.is_left) begin
                    stg[s+1][i] = (i >= k && off >= 7'(k)) ? stg[s][i-k] : 1'b0;
                end else if (i + k < VLEN && 8'(off) + 8'(k) <= 8'(off_mask)) begin
                    stg[s+1][i] = stg[s][i+k];
                end else begin
                    stg[s+1][i] = fill[i/8];
                end
            end
        end
    end

    assign result = ctrl.is_shift ? stg[7] : '0;

    // Decoder never issues a left arithmetic shift
    a_no_left_arith: assert final (
        !(srca.valid && ctrl.is_shift && ctrl.is_left && ctrl.is_arith)
    );

endmodule

// File: source/riscv_v_logic_alu.sv
// Logic ALU, one registered result per issue, no stall
// srca.valid is the issue strobe, result.valid follows one cycle later
// Result data holds its last value between issues
`timescale 1ns/1ns

module riscv_v_logic_alu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  riscv_v_ctrl_pkg::riscv_v_op_e   op,
    input  riscv_v_ctrl_pkg::osize_vector_t osize_vector,
    input  riscv_v_pkg::riscv_v_alu_data_t  srca,
    input  riscv_v_pkg::riscv_v_alu_data_t  srcb,
    output riscv_v_pkg::riscv_v_wb_data_t   result
);
    import riscv_v_ctrl_pkg::*;
    import riscv_v_pkg::*;

    riscv_v_logic_ctrl_t ctrl;
    logic [4:1]          is_greater_osize_vector;
    logic [3:0]          is_less_osize_vector;
    riscv_v_lane_u       bw_result;
    riscv_v_lane_u       shifter_result;
    logic                valid_q;
    riscv_v_lane_u       data_q;

    always_comb begin
        ctrl = '0;
        case (op)
            OP_AND:    ctrl.is_and = 1'b1;
            OP_OR:     ctrl.is_or  = 1'b1;
            OP_XOR:    ctrl.is_xor = 1'b1;
            OP_REDAND: {ctrl.is_reduct, ctrl.is_and} = 2'b11;
            OP_REDOR:  {ctrl.is_reduct, ctrl.is_or}  = 2'b11;
            OP_REDXOR: {ctrl.is_reduct, ctrl.is_xor} = 2'b11;
            OP_SLL:    {ctrl.is_shift, ctrl.is_left}  = 2'b11;
            OP_SRL:    ctrl.is_shift = 1'b1;
            OP_SRA:    {ctrl.is_shift, ctrl.is_arith} = 2'b11;
            default:   ctrl = '0;
        endcase
    end

    // Size masks, bit n of greater means wider than 8 << (n - 1)
    assign is_greater_osize_vector = {osize_vector[4],
                                      |osize_vector[4:3],
                                      ~osize_vector[1] & ~osize_vector[0],
                                      ~osize_vector[0]};
    assign is_less_osize_vector    = ~is_greater_osize_vector;

    riscv_v_bw_unit u_bw_unit (
        .ctrl                    (ctrl),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (srca),
        .srcb                    (srcb),
        .result                  (bw_result)
    );

    riscv_v_shifter u_shifter (
        .ctrl                    (ctrl),
        .osize_vector            (osize_vector),
        .is_less_osize_vector    (is_less_osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (srca),
        .srcb                    (srcb),
        .result                  (shifter_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= srca.valid;
        end
    end

    // Unselected units drive zero, so OR is the merge
    always_ff @(posedge clk) begin
        if (srca.valid) begin
            data_q <= bw_result.q | shifter_result.q;
        end
    end

    assign result = '{valid: valid_q, data: data_q};

    a_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n) srca.valid |-> op inside {[OP_AND:OP_SRA]}
    );

endmodule

// File: source/riscv_v_logic_unit.sv
// Vector logic slice top, configuration register plus logic ALU
// No handshake, one issue per cycle at most and no back-pressure
// Masking, tail handling and LMUL grouping are not supported
`timescale 1ns/1ns

module riscv_v_logic_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_we,
    input  riscv_v_ctrl_pkg::riscv_v_sew_e cfg_sew,
    input  logic                          issue,
    input  riscv_v_ctrl_pkg::riscv_v_op_e  op,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    output riscv_v_pkg::riscv_v_wb_data_t  result,
    output logic                          cfg_err
);
    import riscv_v_ctrl_pkg::*;
    import riscv_v_pkg::*;

    osize_vector_t     osize_vector;
    riscv_v_alu_data_t srca_iss;
    riscv_v_alu_data_t srcb_iss;

    // Issue strobe rides in the operand valid bits
    assign srca_iss = '{valid: issue, data: srca.data};
    assign srcb_iss = '{valid: issue, data: srcb.data};

    riscv_v_alu_cfg u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg_sew      (cfg_sew),
        .osize_vector (osize_vector),
        .cfg_err      (cfg_err)
    );

    riscv_v_logic_alu u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .op           (op),
        .osize_vector (osize_vector),
        .srca         (srca_iss),
        .srcb         (srcb_iss),
        .result       (result)
    );

endmodule

// File: tb/tb_riscv_v_logic_unit.sv
// Table-driven testbench for the vector logic slice top level
// Expected values in the table are worked out by hand per SEW
// The back-to-back section uses a reference model at SEW 16
`timescale 1ns/1ns

module tb_riscv_v_logic_unit;
    import riscv_v_ctrl_pkg::*;
    import riscv_v_pkg::*;

    localparam int NUM_ROWS    = 14;
    localparam int CYCLE_LIMIT = NUM_ROWS * 4 + 20;

    typedef struct {
        string            name;
        logic             cfg;
        logic [2:0]       sew;
        riscv_v_op_e      op;
        logic [VLEN-1:0]  a;
        logic [VLEN-1:0]  b;
        riscv_v_wb_data_t exp;
        logic             exp_err;
    } test_row_t;

    logic              clk;
    logic              rst_n;
    logic              cfg_we;
    riscv_v_sew_e      cfg_sew;
    logic              issue;
    riscv_v_op_e       op;
    riscv_v_alu_data_t srca;
    riscv_v_alu_data_t srcb;
    riscv_v_wb_data_t  result;
    logic              cfg_err;

    test_row_t         rows[$];
    int                errors;
    int                errs;
    int                pass_count;
    int                fail_count;
    int                cycles;
    int                seed = 32'h3f49;
    logic [VLEN-1:0]   b2b_a;
    logic [VLEN-1:0]   b2b_b;
    logic [31:0]       rnd;
    riscv_v_op_e       b2b_op;
    riscv_v_wb_data_t  b2b_exp[3];

    riscv_v_logic_unit DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_we  (cfg_we),
        .cfg_sew (cfg_sew),
        .issue   (issue),
        .op      (op),
        .srca    (srca),
        .srcb    (srcb),
        .result  (result),
        .cfg_err (cfg_err)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, the run hung after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic add_row(input string name, input logic cfg, input logic [2:0] sew,
                           input riscv_v_op_e op_i, input logic [VLEN-1:0] a,
                           input logic [VLEN-1:0] b, input logic [VLEN-1:0] e,
                           input logic exp_err);
        test_row_t r;
        r.name       = name;
        r.cfg        = cfg;
        r.sew        = sew;
        r.op         = op_i;
        r.a          = a;
        r.b          = b;
        r.exp.valid  = 1'b1;
        r.exp.data.q = e;
        r.exp_err    = exp_err;
        rows.push_back(r);
    endtask

    task automatic check_wb(input string name, input riscv_v_wb_data_t exp);
        if (result !== exp) begin
            $display("[ERROR] %s expected valid=%b data=%h actual valid=%b data=%h",
                     name, exp.valid, exp.data.q, result.valid, result.data.q);
            errors++;
        end
    endtask

    task automatic check_err(input string name, input logic exp);
        if (cfg_err !== exp) begin
            $display("[ERROR] %s expected cfg_err=%b actual cfg_err=%b", name, exp, cfg_err);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("[TEST] %s passed", name);
        end else begin
            fail_count++;
            $display("[TEST] %s failed", name);
        end
    endtask

    // Element w bits wide, shift amount is the element value modulo w
    function automatic logic [VLEN-1:0] ref_result(input riscv_v_op_e f_op, input int w,
                                                   input logic [VLEN-1:0] a,
                                                   input logic [VLEN-1:0] b);
        logic [VLEN-1:0] mask;
        logic [VLEN-1:0] ea;
        logic [VLEN-1:0] eb;
        logic [VLEN-1:0] fill;
        logic [VLEN-1:0] res;
        int              sh;
        mask = {VLEN{1'b1}} >> (VLEN - w);
        res  = (f_op inside {OP_REDAND, OP_REDOR, OP_REDXOR}) ? (a & mask) : '0;
        for (int i = 0; i < VLEN / w; i++) begin
            ea   = (a >> (i * w)) & mask;
            eb   = (b >> (i * w)) & mask;
            sh   = int'(eb[6:0]) % w;
            fill = ea[w-1] ? (mask & ~(mask >> sh)) : '0;
            case (f_op)
                OP_AND:    res |= (ea & eb) << (i * w);
                OP_OR:     res |= (ea | eb) << (i * w);
                OP_XOR:    res |= (ea ^ eb) << (i * w);
                OP_REDAND: res = res & eb;
                OP_REDOR:  res = res | eb;
                OP_REDXOR: res = res ^ eb;
                OP_SLL:    res |= ((ea << sh) & mask) << (i * w);
                OP_SRL:    res |= (ea >> sh) << (i * w);
                default:   res |= ((ea >> sh) | fill) << (i * w);
            endcase
        end
        return res;
    endfunction

    initial begin
        rst_n   = 1'b0;
        cfg_we  = 1'b0;
        cfg_sew = SEW_8;
        issue   = 1'b0;
        op      = OP_AND;
        srca    = '0;
        srcb    = '0;
        cycles  = 0;

        // First row runs on the size left by reset
        add_row("and_reset_sew8", 1'b0, 3'd0, OP_AND, 128'h0123456789abcdeffedcba9876543210,
            128'hff00ff00ff00ff000f0f0f0f0f0f0f0f, 128'h010045008900cd000e0c0a0806040200, 0);
        add_row("or_sew8", 1'b1, 3'd0, OP_OR, 128'h00ff00ff00ff00ff123456789abcdef0,
            128'hf0f0f0f00f0f0f0f0000000011111111, 128'hf0fff0ff0fff0fff123456789bbddff1, 0);
        add_row("xor_sew64", 1'b1, 3'd3, OP_XOR, 128'haaaaaaaaaaaaaaaa5555555555555555,
            128'hffffffff00000000ffffffff00000000, 128'h55555555aaaaaaaaaaaaaaaa55555555, 0);
        add_row("redand_sew16", 1'b1, 3'd1, OP_REDAND, 128'h123456789abcdef0000011112222fffe,
            128'hfffffff7ffffff7fffffffffefffffff, 128'h0000000000000000000000000000ef76, 0);
        add_row("redor_sew16", 1'b1, 3'd1, OP_REDOR, 128'hffffffffffffffffffffffffffff0808,
            128'h00010000002000000300000040000000, 128'h00000000000000000000000000004b29, 0);
        add_row("redxor_sew32", 1'b1, 3'd2, OP_REDXOR, 128'haaaaaaaabbbbbbbbcccccccc0f0f0f0f,
            128'h88888888444444442222222211111111, 128'h000000000000000000000000f0f0f0f0, 0);
        add_row("redand_sew32", 1'b1, 3'd2, OP_REDAND, 128'h000000000000000000000000ff0ff0ff,
            128'hfffffffffffffff00fffffffffff00ff, 128'h0000000000000000000000000f0f00f0, 0);
        add_row("sll_sew8", 1'b1, 3'd0, OP_SLL, 128'h81818181818181818181818181818181,
            128'hf8090afb0c0d0e0f0001020304050607, 128'h81020408102040808102040810204080, 0);
        add_row("sra_sew8", 1'b1, 3'd0, OP_SRA, 128'h80808080808080807f7f7f7f7f7f7f7f,
            128'hf8090afb0c0d0e0f0001020304050607, 128'h80c0e0f0f8fcfeff7f3f1f0f07030100, 0);
        add_row("srl_sew32", 1'b1, 3'd2, OP_SRL, 128'h80000001ffffffff12345678f0000000,
            128'hffffffe1000000240000001f00000020, 128'h400000000fffffff00000000f0000000, 0);
        add_row("sra_sew32", 1'b1, 3'd2, OP_SRA, 128'h80000001ffffffff9234567870000000,
            128'hffffffe1000000240000001f00000020, 128'hc0000000ffffffffffffffff70000000, 0);
        add_row("sll_sew128", 1'b1, 3'd4, OP_SLL, 128'h00000000000000000000000012345678,
            128'hffffffffffffffffffffffffffffffc4, 128'h00000001234567800000000000000000, 0);
        add_row("sra_sew128", 1'b1, 3'd4, OP_SRA, 128'h80000000000000000000000000000000,
            128'h000000000000000000000000000000bf, 128'hffffffffffffffff0000000000000000, 0);
        // Code 6 is reserved, SEW 128 must stay active
        add_row("srl_rsvd_sew", 1'b1, 3'd6, OP_SRL, 128'hf0000000000000000000000000000000,
            128'h00000000000000000000000000000004, 128'h0f000000000000000000000000000000, 1);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errs = errors;
        if (result.valid !== 1'b0) begin
            $display("[ERROR] reset expected valid=0 actual valid=%b", result.valid);
            errors++;
        end
        check_err("reset", 1'b0);
        finish_test("reset", errs);

        foreach (rows[i]) begin
            errs = errors;
            @(posedge clk);
            cfg_we  <= rows[i].cfg;
            cfg_sew <= riscv_v_sew_e'(rows[i].sew);
            @(posedge clk);
            cfg_we       <= 1'b0;
            issue        <= 1'b1;
            op           <= rows[i].op;
            srca.data.q  <= rows[i].a;
            srcb.data.q  <= rows[i].b;
            @(negedge clk);
            if (result.valid !== 1'b0) begin
                $display("[ERROR] %s expected valid=0 before issue actual valid=%b",
                         rows[i].name, result.valid);
                errors++;
            end
            @(posedge clk);
            issue <= 1'b0;
            @(negedge clk);
            check_wb(rows[i].name, rows[i].exp);
            check_err(rows[i].name, rows[i].exp_err);
            finish_test(rows[i].name, errs);
        end

        // Three issues in a row at SEW 16, each result checked one cycle later
        errs = errors;
        @(posedge clk);
        cfg_we  <= 1'b1;
        cfg_sew <= SEW_16;
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            cfg_we <= 1'b0;
            if (k < 3) begin
                b2b_a  = {$random(seed), $random(seed), $random(seed), $random(seed)};
                b2b_b  = {$random(seed), $random(seed), $random(seed), $random(seed)};
                rnd    = $unsigned($random(seed)) % 9;
                b2b_op = riscv_v_op_e'(rnd[3:0]);
                b2b_exp[k].valid  = 1'b1;
                b2b_exp[k].data.q = ref_result(b2b_op, 16, b2b_a, b2b_b);
                issue       <= 1'b1;
                op          <= b2b_op;
                srca.data.q <= b2b_a;
                srcb.data.q <= b2b_b;
            end else begin
                issue <= 1'b0;
            end
            @(negedge clk);
            if (k > 0) begin
                check_wb($sformatf("back_to_back_%0d", k - 1), b2b_exp[k - 1]);
            end
        end
        finish_test("back_to_back", errs);

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sim.f
source/riscv_v_ctrl_pkg.sv
source/riscv_v_pkg.sv
source/riscv_v_alu_cfg.sv
source/riscv_v_bw_unit.sv
source/riscv_v_shifter.sv
source/riscv_v_logic_alu.sv
source/riscv_v_logic_unit.sv
tb/tb_riscv_v_logic_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_riscv_v_logic_unit \
    --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
